// File: rtl/soc_ctrl_consts.svh
`ifndef SOC_CTRL_CONSTS_SVH
`define SOC_CTRL_CONSTS_SVH

// word indices, taken from address bits 6:2
`define REG_PADFUN0     5'd0
`define REG_CLKDIV0     5'd2
`define REG_CLKDIV1     5'd3
`define REG_INFO        5'd4
`define REG_MMARGIN     5'd6
`define REG_PADCFG0     5'd7
`define REG_PADCFG1     5'd8
`define REG_PADCFG2     5'd9
`define REG_PADCFG3     5'd10
`define REG_PWRCFG      5'd17
`define REG_CLKDIV2     5'd19

`define APB_ADDR_W      12

`define NB_CLKDIV       3
`define NB_PADS         16
`define PAD_CFG_W       6

// L2 margin field widths
`define RM_SIZE         4
`define WM_SIZE         4

`define NB_CORES        4
`define NB_CLUSTERS     1

`define CLKDIV_RST0     8'h00
`define CLKDIV_RST1     8'h00
`define CLKDIV_RST2     8'h0A

`define PAD_CFG_RST     6'h3F
`define PM_WAIT_RST     8'h0F

`endif

// File: rtl/soc_ctrl_pkg.sv
`include "soc_ctrl_consts.svh"

package soc_ctrl_pkg;

    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
        logic                   pwrite;
        logic                   psel;
        logic                   penable;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [4:0] {
        REG_PADFUN0 = `REG_PADFUN0,
        REG_CLKDIV0 = `REG_CLKDIV0,
        REG_CLKDIV1 = `REG_CLKDIV1,
        REG_INFO    = `REG_INFO,
        REG_MMARGIN = `REG_MMARGIN,
        REG_PADCFG0 = `REG_PADCFG0,
        REG_PADCFG1 = `REG_PADCFG1,
        REG_PADCFG2 = `REG_PADCFG2,
        REG_PADCFG3 = `REG_PADCFG3,
        REG_PWRCFG  = `REG_PWRCFG,
        REG_CLKDIV2 = `REG_CLKDIV2,
        REG_NONE    = 5'd31         // unmapped
    } reg_idx_e;

    typedef struct packed {
        logic [7:0] rst_wait;
        logic [7:0] busy_wait;
        logic [2:0] bbgen_sel;
        logic [4:0] wakeup_sel;
        logic [1:0] bbgen_dat;
        logic       bbgen_req;
        logic       wakeup_pol;
        logic [1:0] rsvd;
        logic       cluster_rst_req;
        logic       power_down_req;
    } pwrcfg_t;

    typedef struct packed {
        logic [1:0]            rsvd;
        logic [`PAD_CFG_W-1:0] cfg;
    } pad_slot_t;

    typedef pad_slot_t [3:0] padcfg_word_t;     // slot 0 in the low byte

    typedef union packed {
        logic [31:0]  raw;
        pwrcfg_t      pwr;
        padcfg_word_t pad;
    } wdata_u;

    typedef struct packed {
        reg_idx_e idx;
        wdata_u   data;
    } reg_wr_t;

    typedef struct packed {
        logic [`WM_SIZE-1:0] wm;
        logic [`RM_SIZE-1:0] rm;
    } l2_margin_t;

    typedef struct packed {
        logic [7:0] rst_wait;
        logic [7:0] busy_wait;
        logic [2:0] bbgen_sel;
        logic [4:0] wakeup_sel;
        logic [1:0] bbgen_dat;
        logic       bbgen_req;
        logic       wakeup_pol;
        logic       cluster_rst_req;
        logic       power_down_req;
    } pm_cfg_t;

    typedef logic [`NB_CLKDIV-1:0][7:0] clkdiv_bus_t;

endpackage

// File: rtl/apb_reg_decoder.sv
`include "soc_ctrl_consts.svh"

module apb_reg_decoder
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  soc_ctrl_pkg::apb_req_t apb_req_i,
    input  logic [31:0]            rd_data_i,
    output logic                   wr_stb_o,
    output soc_ctrl_pkg::reg_wr_t  wr_o,
    output soc_ctrl_pkg::reg_idx_e rd_idx_o,
    output soc_ctrl_pkg::apb_rsp_t apb_rsp_o
);
    import soc_ctrl_pkg::*;

    reg_idx_e idx;
    logic     access;
    logic     wr_access;

    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign wr_access = access && apb_req_i.pwrite;

    always_comb
    begin
        idx = REG_NONE;
        if (apb_req_i.paddr[`APB_ADDR_W-1:7] == '0)     // only the low 128 bytes are mapped
        begin
            case (apb_req_i.paddr[6:2])
                `REG_PADFUN0: idx = REG_PADFUN0;
                `REG_CLKDIV0: idx = REG_CLKDIV0;
                `REG_CLKDIV1: idx = REG_CLKDIV1;
                `REG_CLKDIV2: idx = REG_CLKDIV2;
                `REG_INFO:    idx = REG_INFO;
                `REG_MMARGIN: idx = REG_MMARGIN;
                `REG_PADCFG0: idx = REG_PADCFG0;
                `REG_PADCFG1: idx = REG_PADCFG1;
                `REG_PADCFG2: idx = REG_PADCFG2;
                `REG_PADCFG3: idx = REG_PADCFG3;
                `REG_PWRCFG:  idx = REG_PWRCFG;
                default:      idx = REG_NONE;
            endcase
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            wr_stb_o <= 1'b0;
        else
            wr_stb_o <= wr_access && (idx != REG_NONE) && (idx != REG_INFO);
    end

    always_ff @(posedge HCLK)
    begin
        if (wr_access)
        begin
            wr_o.idx      <= idx;
            wr_o.data.raw <= apb_req_i.pwdata;
        end
    end

    assign rd_idx_o = idx;

    assign apb_rsp_o.prdata  = (idx == REG_NONE) ? 32'h0 : rd_data_i;
    assign apb_rsp_o.pready  = 1'b1;                    // no wait states
    assign apb_rsp_o.pslverr = access && (idx == REG_NONE);

    // a strobe only follows a write access phase, and never to a read-only or hole
    a_stb_from_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
        wr_stb_o |-> $past(wr_access) && !(wr_o.idx inside {REG_NONE, REG_INFO}));

endmodule

// File: rtl/soc_ctrl_regs.sv
`include "soc_ctrl_consts.svh"

module soc_ctrl_regs
(
    input  logic                                   HCLK,
    input  logic                                   HRESETn,
    input  logic                                   wr_stb_i,
    input  soc_ctrl_pkg::reg_wr_t                  wr_i,
    input  soc_ctrl_pkg::reg_idx_e                 rd_idx_i,
    output logic [31:0]                            rd_data_o,
    output soc_ctrl_pkg::clkdiv_bus_t              clkdiv_o,
    output soc_ctrl_pkg::pm_cfg_t                  pm_cfg_o,
    output logic [`NB_PADS-1:0][`PAD_CFG_W-1:0]    pad_cfg_o,
    output logic [`NB_PADS-1:0]                    pad_mux_o,
    output soc_ctrl_pkg::l2_margin_t               l2_margin_o,
    output logic [`NB_CLKDIV-1:0]                  clkdiv_upd_o,
    output logic                                   pm_upd_o
);
    import soc_ctrl_pkg::*;

    logic [`NB_PADS-1:0]                 r_pad_fun;
    clkdiv_bus_t                         r_clkdiv;
    pm_cfg_t                             r_pm;
    logic [`NB_PADS-1:0][`PAD_CFG_W-1:0] r_pad_cfg;
    l2_margin_t                          r_margin;

    logic [`NB_CLKDIV-1:0] clkdiv_hit;
    logic                  pm_hit;
    logic                  padcfg_hit;
    logic [1:0]            wr_grp;
    logic [1:0]            rd_grp;
    wdata_u                rd_word;

    // which register the current strobe lands on
    always_comb
    begin
        clkdiv_hit = '0;
        pm_hit     = 1'b0;
        padcfg_hit = 1'b0;
        if (wr_stb_i)
        begin
            case (wr_i.idx)
                REG_CLKDIV0: clkdiv_hit[0] = 1'b1;
                REG_CLKDIV1: clkdiv_hit[1] = 1'b1;
                REG_CLKDIV2: clkdiv_hit[2] = 1'b1;
                REG_PWRCFG:  pm_hit        = 1'b1;
                REG_PADCFG0, REG_PADCFG1, REG_PADCFG2, REG_PADCFG3:
                    padcfg_hit = 1'b1;
                default: ;
            endcase
        end
    end

    assign wr_grp = 2'(wr_i.idx - REG_PADCFG0);     // four pads per word
    assign rd_grp = 2'(rd_idx_i - REG_PADCFG0);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            r_pad_fun  <= '0;
            r_clkdiv   <= {`CLKDIV_RST2, `CLKDIV_RST1, `CLKDIV_RST0};
            r_margin   <= '0;
            r_pad_cfg  <= {`NB_PADS{`PAD_CFG_RST}};
            r_pm       <= '0;
            r_pm.wakeup_pol <= 1'b1;
            r_pm.busy_wait  <= `PM_WAIT_RST;
            r_pm.rst_wait   <= `PM_WAIT_RST;
        end
        else
        begin
            for (int i = 0; i < `NB_CLKDIV; i++)
            begin
                if (clkdiv_hit[i])
                    r_clkdiv[i] <= wr_i.data.raw[7:0];
            end
            if (padcfg_hit)
            begin
                for (int s = 0; s < 4; s++)
                    r_pad_cfg[4*wr_grp + s] <= wr_i.data.pad[s].cfg;
            end
            if (pm_hit)
            begin
                r_pm.rst_wait        <= wr_i.data.pwr.rst_wait;
                r_pm.busy_wait       <= wr_i.data.pwr.busy_wait;
                r_pm.bbgen_sel       <= wr_i.data.pwr.bbgen_sel;
                r_pm.wakeup_sel      <= wr_i.data.pwr.wakeup_sel;
                r_pm.bbgen_dat       <= wr_i.data.pwr.bbgen_dat;
                r_pm.bbgen_req       <= wr_i.data.pwr.bbgen_req;
                r_pm.wakeup_pol      <= wr_i.data.pwr.wakeup_pol;
                r_pm.cluster_rst_req <= wr_i.data.pwr.cluster_rst_req;
                r_pm.power_down_req  <= wr_i.data.pwr.power_down_req;
            end
            if (wr_stb_i && wr_i.idx == REG_PADFUN0)
                r_pad_fun <= wr_i.data.raw[`NB_PADS-1:0];
            if (wr_stb_i && wr_i.idx == REG_MMARGIN)
                r_margin <= wr_i.data.raw[$bits(l2_margin_t)-1:0];
        end
    end

    // update pulses leave on the same edge as the new value
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            clkdiv_upd_o <= '0;
            pm_upd_o     <= 1'b0;
        end
        else
        begin
            clkdiv_upd_o <= clkdiv_hit;
            pm_upd_o     <= pm_hit;
        end
    end

    always_comb
    begin
        rd_word.raw = '0;
        case (rd_idx_i)
            REG_PADFUN0: rd_word.raw[`NB_PADS-1:0] = r_pad_fun;
            REG_CLKDIV0: rd_word.raw[7:0] = r_clkdiv[0];
            REG_CLKDIV1: rd_word.raw[7:0] = r_clkdiv[1];
            REG_CLKDIV2: rd_word.raw[7:0] = r_clkdiv[2];
            REG_INFO:    rd_word.raw = {16'(`NB_CORES), 16'(`NB_CLUSTERS)};
            REG_MMARGIN: rd_word.raw[$bits(l2_margin_t)-1:0] = r_margin;
            REG_PADCFG0, REG_PADCFG1, REG_PADCFG2, REG_PADCFG3:
            begin
                for (int s = 0; s < 4; s++)
                    rd_word.pad[s].cfg = r_pad_cfg[4*rd_grp + s];
            end
            REG_PWRCFG:
            begin
                rd_word.pwr.rst_wait        = r_pm.rst_wait;
                rd_word.pwr.busy_wait       = r_pm.busy_wait;
                rd_word.pwr.bbgen_sel       = r_pm.bbgen_sel;
                rd_word.pwr.wakeup_sel      = r_pm.wakeup_sel;
                rd_word.pwr.bbgen_dat       = r_pm.bbgen_dat;
                rd_word.pwr.bbgen_req       = r_pm.bbgen_req;
                rd_word.pwr.wakeup_pol      = r_pm.wakeup_pol;
                rd_word.pwr.cluster_rst_req = r_pm.cluster_rst_req;
                rd_word.pwr.power_down_req  = r_pm.power_down_req;
            end
            default: ;
        endcase
    end

    assign rd_data_o   = rd_word.raw;
    assign clkdiv_o    = r_clkdiv;
    assign pm_cfg_o    = r_pm;
    assign pad_cfg_o   = r_pad_cfg;
    assign pad_mux_o   = r_pad_fun;
    assign l2_margin_o = r_margin;

    // one channel per write, and only in reply to a strobe
    a_upd_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
        |{clkdiv_upd_o, pm_upd_o} |-> $onehot0({clkdiv_upd_o, pm_upd_o}) && $past(wr_stb_i));

endmodule

// File: rtl/change_notifier.sv
module change_notifier
(
    input  logic HCLK,
    input  logic HRESETn,
    input  logic upd_stb_i,
    input  logic ack_i,
    output logic valid_o
);

    logic [1:0] ack_sync;
    logic       armed;      // ack seen low since the last handshake ended

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            ack_sync <= 2'b00;
            armed    <= 1'b0;
            valid_o  <= 1'b0;
        end
        else
        begin
            ack_sync <= {ack_sync[0], ack_i};
            if (upd_stb_i)
                valid_o <= 1'b1;            // held, not restarted
            else if (valid_o && ack_sync[1] && armed)
                valid_o <= 1'b0;

            if (!ack_sync[1])
                armed <= 1'b1;
            else if (valid_o && !upd_stb_i && armed)
                armed <= 1'b0;              // wait for the old ack to drop
        end
    end

    a_fall_on_ack: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $fell(valid_o) |-> $past(ack_sync[1]));

endmodule

// File: rtl/apb_soc_ctrl.sv
`include "soc_ctrl_consts.svh"

module apb_soc_ctrl
(
    input  logic                                HCLK,
    input  logic                                HRESETn,
    input  soc_ctrl_pkg::apb_req_t              apb_req_i,
    output soc_ctrl_pkg::apb_rsp_t              apb_rsp_o,
    output soc_ctrl_pkg::clkdiv_bus_t           clkdiv_o,
    output logic [`NB_CLKDIV-1:0]               clkdiv_valid_o,
    input  logic [`NB_CLKDIV-1:0]               clkdiv_ack_i,
    output soc_ctrl_pkg::pm_cfg_t               pm_cfg_o,
    output logic                                pm_valid_o,
    input  logic                                pm_ack_i,
    output logic [`NB_PADS-1:0][`PAD_CFG_W-1:0] pad_cfg_o,
    output logic [`NB_PADS-1:0]                 pad_mux_o,
    output soc_ctrl_pkg::l2_margin_t            l2_margin_o
);
    import soc_ctrl_pkg::*;

    logic                  wr_stb;
    reg_wr_t               wr;
    reg_idx_e              rd_idx;
    logic [31:0]           rd_data;
    logic [`NB_CLKDIV-1:0] clkdiv_upd;
    logic                  pm_upd;

    apb_reg_decoder i_decoder
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .apb_req_i (apb_req_i),
        .rd_data_i (rd_data),
        .wr_stb_o  (wr_stb),
        .wr_o      (wr),
        .rd_idx_o  (rd_idx),
        .apb_rsp_o (apb_rsp_o)
    );

    soc_ctrl_regs i_regs
    (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .wr_stb_i     (wr_stb),
        .wr_i         (wr),
        .rd_idx_i     (rd_idx),
        .rd_data_o    (rd_data),
        .clkdiv_o     (clkdiv_o),
        .pm_cfg_o     (pm_cfg_o),
        .pad_cfg_o    (pad_cfg_o),
        .pad_mux_o    (pad_mux_o),
        .l2_margin_o  (l2_margin_o),
        .clkdiv_upd_o (clkdiv_upd),
        .pm_upd_o     (pm_upd)
    );

    // one handshake per divider
    for (genvar i = 0; i < `NB_CLKDIV; i++)
    begin : g_clkdiv_notify
        change_notifier i_notify
        (
            .HCLK      (HCLK),
            .HRESETn   (HRESETn),
            .upd_stb_i (clkdiv_upd[i]),
            .ack_i     (clkdiv_ack_i[i]),
            .valid_o   (clkdiv_valid_o[i])
        );
    end

    change_notifier i_pm_notify
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .upd_stb_i (pm_upd),
        .ack_i     (pm_ack_i),
        .valid_o   (pm_valid_o)
    );

endmodule

// File: test/tb_soc_ctrl.sv
`include "soc_ctrl_consts.svh"

module tb_soc_ctrl;
    import soc_ctrl_pkg::*;

    typedef logic [`NB_PADS-1:0][`PAD_CFG_W-1:0] pad_cfg_t;
    typedef struct packed {
        int          at;            // cycle at which the event is due
        int          ch;
        logic [4:0]  idx;
        logic [31:0] data;
    } pend_t;

    localparam int NUM_TXN   = 400;
    localparam int CYC_LIMIT = NUM_TXN * 40;

    logic                  HCLK;
    logic                  HRESETn;
    apb_req_t              req;
    apb_req_t              nxt;
    apb_rsp_t              rsp;
    clkdiv_bus_t           clkdiv;
    logic [`NB_CLKDIV-1:0] clkdiv_valid;
    pm_cfg_t               pm_cfg;
    logic                  pm_valid;
    pad_cfg_t              pad_cfg;
    logic [`NB_PADS-1:0]   pad_mux;
    l2_margin_t            margin;
    logic [`NB_CLKDIV:0]   ack;         // power manager on the top bit
    logic [`NB_CLKDIV:0]   prev_v;
    logic [`NB_CLKDIV:0]   fell;
    int                    ag_dly [0:`NB_CLKDIV];

    integer      seed;
    int          cyc = 0;
    logic [31:0] shadow [0:31];         // register words as seen on the outputs
    pend_t       wr_q[$];
    pend_t       rise_q[$];

    apb_soc_ctrl dut_i
    (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .apb_req_i      (req),
        .apb_rsp_o      (rsp),
        .clkdiv_o       (clkdiv),
        .clkdiv_valid_o (clkdiv_valid),
        .clkdiv_ack_i   (ack[`NB_CLKDIV-1:0]),
        .pm_cfg_o       (pm_cfg),
        .pm_valid_o     (pm_valid),
        .pm_ack_i       (ack[`NB_CLKDIV]),
        .pad_cfg_o      (pad_cfg),
        .pad_mux_o      (pad_mux),
        .l2_margin_o    (margin)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    always @(posedge HCLK)
    begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT)
            abort_run($sformatf("timeout, the run did not end within %0d cycles", CYC_LIMIT));
    end

    function automatic int urand(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic idx_mapped(logic [4:0] idx);
        case (idx)
            `REG_PADFUN0, `REG_CLKDIV0, `REG_CLKDIV1, `REG_CLKDIV2, `REG_INFO, `REG_MMARGIN,
            `REG_PADCFG0, `REG_PADCFG1, `REG_PADCFG2, `REG_PADCFG3, `REG_PWRCFG: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] wmask(logic [4:0] idx);
        case (idx)
            `REG_PADFUN0: return 32'h0000_FFFF;
            `REG_CLKDIV0, `REG_CLKDIV1, `REG_CLKDIV2, `REG_MMARGIN: return 32'h0000_00FF;
            `REG_PADCFG0, `REG_PADCFG1, `REG_PADCFG2, `REG_PADCFG3: return 32'h3F3F_3F3F;
            `REG_PWRCFG: return 32'hFFFF_FFF3;      // bits 3:2 reserved
            default: return 32'h0;
        endcase
    endfunction

    function automatic int notify_ch(logic [4:0] idx);
        case (idx)
            `REG_CLKDIV0: return 0;
            `REG_CLKDIV1: return 1;
            `REG_CLKDIV2: return 2;
            `REG_PWRCFG:  return `NB_CLKDIV;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [4:0] pick_writable();
        case (urand(10))
            0: return `REG_PADFUN0;
            1: return `REG_CLKDIV0;
            2: return `REG_CLKDIV1;
            3: return `REG_CLKDIV2;
            4: return `REG_MMARGIN;
            5: return `REG_PADCFG0;
            6: return `REG_PADCFG1;
            7: return `REG_PADCFG2;
            8: return `REG_PADCFG3;
            default: return `REG_PWRCFG;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH apb_rsp_o: got %h, expected %h", got, exp));
    endtask

    task automatic check_pm(input pm_cfg_t got, input pm_cfg_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH pm_cfg_o: got %h, expected %h", got, exp));
    endtask

    task automatic check_clkdiv(input clkdiv_bus_t got, input clkdiv_bus_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH clkdiv_o: got %h, expected %h", got, exp));
    endtask

    task automatic check_margin(input l2_margin_t got, input l2_margin_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH l2_margin_o: got %h, expected %h", got, exp));
    endtask

    task automatic check_pads(input pad_cfg_t got_cfg, input pad_cfg_t exp_cfg,
                              input logic [`NB_PADS-1:0] got_mux,
                              input logic [`NB_PADS-1:0] exp_mux);
        if (got_cfg !== exp_cfg)
            abort_run($sformatf("MISMATCH pad_cfg_o: got %h, expected %h", got_cfg, exp_cfg));
        if (got_mux !== exp_mux)
            abort_run($sformatf("MISMATCH pad_mux_o: got %h, expected %h", got_mux, exp_mux));
    endtask

    task automatic compare_outputs();
        pad_cfg_t    exp_pads;
        logic [31:0] pw;
        pw = shadow[`REG_PWRCFG];
        for (int p = 0; p < `NB_PADS; p++)
            exp_pads[p] = shadow[`REG_PADCFG0 + p / 4][8 * (p % 4) +: `PAD_CFG_W];
        check_pads(pad_cfg, exp_pads, pad_mux, shadow[`REG_PADFUN0][`NB_PADS-1:0]);
        check_margin(margin, l2_margin_t'(shadow[`REG_MMARGIN][7:0]));
        check_clkdiv(clkdiv, {shadow[`REG_CLKDIV2][7:0], shadow[`REG_CLKDIV1][7:0],
                              shadow[`REG_CLKDIV0][7:0]});
        check_pm(pm_cfg, pm_cfg_t'({pw[31:4], pw[1:0]}));
    endtask

    // four-phase receivers, one per channel
    task automatic run_agents();
        for (int c = 0; c <= `NB_CLKDIV; c++)
        begin
            if (ag_dly[c] > 0)
                ag_dly[c]--;
            else if (!ack[c] && prev_v[c])
            begin
                ack[c] = 1'b1;
                ag_dly[c] = urand(4);
            end
            else if (ack[c] && (fell[c] || !prev_v[c]))
            begin
                ack[c] = 1'b0;
                fell[c] = 1'b0;
                ag_dly[c] = urand(4);
            end
            if (ack[c] && !prev_v[c])
                fell[c] = 1'b1;                     // valid dropped, release ack
        end
    endtask

    task automatic tick();
        logic [`NB_CLKDIV:0] rise;
        logic [`NB_CLKDIV:0] v;
        @(negedge HCLK);
        req = nxt;
        run_agents();
        while (wr_q.size() > 0 && wr_q[0].at <= cyc)
        begin
            shadow[wr_q[0].idx] = wr_q[0].data & wmask(wr_q[0].idx);
            void'(wr_q.pop_front());
        end
        rise = '0;
        while (rise_q.size() > 0 && rise_q[0].at <= cyc)
        begin
            rise[rise_q[0].ch] = 1'b1;
            void'(rise_q.pop_front());
        end
        #1;
        v = {pm_valid, clkdiv_valid};
        for (int c = 0; c <= `NB_CLKDIV; c++)
        begin
            if (rise[c] && !v[c])
                abort_run($sformatf("valid %0d did not rise 3 cycles after its write", c));
            if (!prev_v[c] && v[c] && !rise[c])
                abort_run($sformatf("valid %0d rose with no write behind it", c));
            if (prev_v[c] && !v[c] && !ack[c])
                abort_run($sformatf("valid %0d fell before its ack", c));
        end
        prev_v = v;
        compare_outputs();
    endtask

    task automatic apb_xfer(input logic [`APB_ADDR_W-1:0] addr, input logic wr,
                            input logic [31:0] wdata);
        apb_rsp_t   exp;
        logic [4:0] idx;
        logic       mapped;
        idx = addr[6:2];
        mapped = (addr[`APB_ADDR_W-1:7] == '0) && idx_mapped(idx);
        nxt = '{paddr: addr, pwdata: wdata, pwrite: wr, psel: 1'b1, penable: 1'b0};
        tick();
        exp = '{prdata: mapped ? shadow[idx] : 32'h0, pready: 1'b1, pslverr: 1'b0};
        check_rsp(rsp, exp);
        nxt.penable = 1'b1;
        tick();
        exp = '{prdata: mapped ? shadow[idx] : 32'h0, pready: 1'b1, pslverr: !mapped};
        check_rsp(rsp, exp);
        if (wr && mapped && idx != `REG_INFO)
        begin
            wr_q.push_back('{at: cyc + 2, ch: -1, idx: idx, data: wdata});
            if (notify_ch(idx) >= 0)
                rise_q.push_back('{at: cyc + 3, ch: notify_ch(idx), idx: idx, data: wdata});
        end
        nxt.psel = 1'b0;
        nxt.penable = 1'b0;
    endtask

    initial
    begin
        int                     kind;
        logic [4:0]             idx;
        logic [`APB_ADDR_W-1:0] addr;
        seed = 32'h55dc;
        HRESETn = 1'b0;
        req = '0;
        nxt = '0;
        ack = '0;
        prev_v = '0;
        fell = '0;
        for (int c = 0; c <= `NB_CLKDIV; c++)
            ag_dly[c] = 0;
        for (int i = 0; i < 32; i++)
            shadow[i] = 32'h0;
        shadow[`REG_CLKDIV0] = {24'h0, `CLKDIV_RST0};
        shadow[`REG_CLKDIV1] = {24'h0, `CLKDIV_RST1};
        shadow[`REG_CLKDIV2] = {24'h0, `CLKDIV_RST2};
        for (int i = 0; i < 4; i++)
            shadow[`REG_PADCFG0 + i] = {4{2'b00, `PAD_CFG_RST}};
        shadow[`REG_PWRCFG] = {`PM_WAIT_RST, `PM_WAIT_RST, 11'h0, 1'b1, 4'h0};  // wakeup pol set
        shadow[`REG_INFO] = {16'(`NB_CORES), 16'(`NB_CLUSTERS)};
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        if ({pm_valid, clkdiv_valid} != '0)
            abort_run("a valid output is high right after reset");
        for (int i = 0; i < 32; i++)
        begin
            if (idx_mapped(5'(i)))
                apb_xfer({5'h0, 5'(i), 2'b00}, 1'b0, 32'h0);
        end
        for (int t = 0; t < NUM_TXN; t++)
        begin
            kind = urand(100);
            if (kind < 5)
                repeat (3) apb_xfer({5'h0, `REG_PWRCFG, 2'b00}, 1'b1, $random(seed));
            else
            begin
                if (kind < 70)
                    idx = pick_writable();
                else if (kind < 80)
                    idx = `REG_INFO;
                else
                    idx = 5'(urand(32));
                addr = {5'h0, idx, 2'b00};
                if (kind >= 92)
                    addr[`APB_ADDR_W-1:7] = 5'(urand(31) + 1);  // outside the map
                apb_xfer(addr, urand(2) == 1, $random(seed));
            end
            repeat (urand(3)) tick();
        end
        while (prev_v != '0 || ack != '0 || wr_q.size() > 0 || rise_q.size() > 0)
            tick();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/soc_ctrl_pkg.sv
rtl/apb_reg_decoder.sv
rtl/soc_ctrl_regs.sv
rtl/change_notifier.sv
rtl/apb_soc_ctrl.sv
test/tb_soc_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_soc_ctrl -Mdir obj_dir
./obj_dir/Vtb_soc_ctrl
